/* hw/soc_addr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_addr_decode (
	input  logic                       cpu_clk,
	input  logic                       sys_rst_n,
	input  soc_pkg::mem_req_t          mem_req,
	input  logic [soc_pkg::DATA_W-1:0] ram_rdata,	// Registered by the RAM
	output soc_pkg::mem_sel_t          mem_sel,
	output logic [soc_pkg::DATA_W-1:0] mem_rdata
);
	import soc_pkg::*;

	logic is_sdram;
	logic is_io;
	logic rd_valid;		// Read issued last cycle
	logic rd_ram;		// That read hit RAM
	logic [DATA_W-1:0] rdata_q;	// Held result of the last read

	// ----------------------------------------
	// Region decode
	// ----------------------------------------
	assign is_sdram = mem_req.addr[SDRAM_BIT_HI] | mem_req.addr[SDRAM_BIT_LO];
	assign is_io    = mem_req.addr[IO_REGION_BIT] & ~is_sdram;	// SDRAM takes priority

	always_comb begin
		mem_sel = '0;
		if (is_sdram) begin
			mem_sel.none = 1'b1;	// Window is recognised and ignored
		end else if (is_io) begin
			case (mem_req.addr.io.dev)
				DEV_PORT_A: mem_sel.port_a = 1'b1;
				DEV_LED:    mem_sel.led    = 1'b1;
				DEV_UART:   mem_sel.none   = 1'b1;	// UART removed
				default:    mem_sel.none   = 1'b1;
			endcase
		end else begin
			mem_sel.ram = 1'b1;
		end
	end

	// ----------------------------------------
	// Read return
	// ----------------------------------------
	always_ff @(posedge cpu_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rd_valid <= 1'b0;
			rd_ram   <= 1'b0;
			rdata_q  <= '0;
		end else begin
			if (rd_valid)
				rdata_q <= mem_rdata;	// Keep it until the next read
			rd_valid <= mem_req.rstrb;
			if (mem_req.rstrb)
				rd_ram <= mem_sel.ram;
		end
	end

	// IO and SDRAM reads return zero
	assign mem_rdata = rd_valid ? (rd_ram ? ram_rdata : '0) : rdata_q;

	a_sel_onehot: assert property (
		@(posedge cpu_clk) disable iff (!sys_rst_n)
		$onehot(mem_sel)
	);

endmodule

`default_nettype wire

/* hw/soc_bram.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_bram (
	input  logic                       cpu_clk,
	input  soc_pkg::mem_req_t          mem_req,
	input  soc_pkg::mem_sel_t          mem_sel,
	output logic [soc_pkg::DATA_W-1:0] ram_rdata
);
	import soc_pkg::*;

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	logic [DATA_W-1:0] ram [RAM_WORDS];	// 16K x 32 bits
	logic [RAM_IDX_W-1:0] word_idx;

	assign word_idx = mem_req.addr.ram.word_idx;	// Byte offset ignored

	// Per-lane write enables
	logic [LANES-1:0] lane_we;

	assign lane_we = mem_sel.ram ? mem_req.wmask : '0;

	// ----------------------------------------
	// Write and read port
	// ----------------------------------------
	always_ff @(posedge cpu_clk) begin
		for (int i = 0; i < LANES; i++) begin
			if (lane_we[i])
				ram[word_idx][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
		end

		// Read every cycle, old word on a same-cycle write
		ram_rdata <= ram[word_idx];
	end

endmodule

`default_nettype wire

/* hw/soc_io_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_io_regs (
	input  logic              cpu_clk,
	input  logic              sys_rst_n,	// Holds registers at zero
	input  soc_pkg::mem_req_t mem_req,
	input  soc_pkg::mem_sel_t mem_sel,
	input  logic              halt,		// From the processor
	output logic [7:0]        port_a,
	output logic              port_lb,	// Blue LED
	output logic              port_lr,	// Red LED
	output logic              port_lg	// Green LED
);
	import soc_pkg::*;

	logic       wr_en;		// Any lane enabled
	logic [7:0] wr_byte;	// Byte from the lowest lane

	assign wr_en   = |mem_req.wmask;
	assign wr_byte = lane_pick(mem_req.wdata, mem_req.wmask);

	// ----------------------------------------
	// Port A
	// ----------------------------------------
	always_ff @(posedge cpu_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			port_a <= '0;
		end else if (mem_sel.port_a && wr_en) begin
			port_a <= wr_byte;	// Full byte
		end
	end

	// ----------------------------------------
	// Blue LED
	// ----------------------------------------
	always_ff @(posedge cpu_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			port_lb <= 1'b0;
		end else if (mem_sel.led && wr_en) begin
			port_lb <= wr_byte[0];	// Only bit 0 of the picked byte
		end
	end

	// ----------------------------------------
	// Status LEDs
	// ----------------------------------------
	// Red while halted, green while running
	assign port_lr = halt;
	assign port_lg = ~halt;

	a_leds_exclusive: assert property (
		@(posedge cpu_clk) disable iff (!sys_rst_n)
		!(port_lr && port_lg)
	);

endmodule

`default_nettype wire

/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// ----------------------------------------
	// Bus and map sizes
	// ----------------------------------------
	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int LANES     = 4;		// Byte lanes per word
	localparam int RAM_WORDS = 16384;	// 64 KB of 32-bit words
	localparam int RAM_IDX_W = 14;

	// Region marker bits
	localparam int IO_REGION_BIT = 22;
	localparam int SDRAM_BIT_LO  = 24;	// SDRAM window is bit 24 or 25
	localparam int SDRAM_BIT_HI  = 25;

	// IO device numbers, address bits 15:8
	localparam logic [7:0] DEV_PORT_A = 8'h00;
	localparam logic [7:0] DEV_UART   = 8'h01;	// No device behind it any more
	localparam logic [7:0] DEV_LED    = 8'h02;

	// Reset hold ends once this counter bit sets
	localparam int HOLD_BIT = 3;

	// ----------------------------------------
	// Address word, two decodes
	// ----------------------------------------
	typedef struct packed {
		logic [ADDR_W-RAM_IDX_W-3:0] upper;
		logic [RAM_IDX_W-1:0]        word_idx;	// Bits 15:2
		logic [1:0]                  byte_off;
	} ram_view_t;

	typedef struct packed {
		logic [ADDR_W-17:0] upper;
		logic [7:0]         dev;		// 256 devices
		logic [4:0]         rsvd;
		logic [2:0]         reg_sel;	// Register within a device
	} io_view_t;

	typedef union packed {
		ram_view_t ram;
		io_view_t  io;
	} mem_addr_u;

	// Native processor bus request, 69 bits
	typedef struct packed {
		mem_addr_u         addr;
		logic [DATA_W-1:0] wdata;
		logic [LANES-1:0]  wmask;	// Nonzero means write
		logic              rstrb;	// Read strobe
	} mem_req_t;

	// One-hot target select
	typedef struct packed {
		logic ram;
		logic port_a;
		logic led;
		logic none;
	} mem_sel_t;

	// Byte of the lowest enabled lane, byte 0 if none
	function automatic logic [7:0] lane_pick(input logic [DATA_W-1:0] wdata,
			input logic [LANES-1:0] wmask);
		logic [7:0] pick;
		pick = wdata[7:0];
		for (int i = LANES - 1; i >= 0; i--) begin	// Walk down so lowest wins
			if (wmask[i])
				pick = wdata[i*8 +: 8];
		end
		return pick;
	endfunction

endpackage

`default_nettype wire

/* hw/soc_reset_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_reset_seq (
	input  logic cpu_clk,
	input  logic rst_n,
	input  logic manual_reset,	// Active high, restarts the hold
	output logic sys_rst_n		// Active low system reset
);
	import soc_pkg::*;

	typedef enum logic [2:0] {
		ST_RESET,
		ST_COUNT,
		ST_COMPLETE,
		ST_RELEASE,
		ST_IDLE
	} seq_state_t;

	seq_state_t state;
	seq_state_t next_state;
	logic [HOLD_BIT:0] hold_cnt;	// Hold counter

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			ST_RESET:    next_state = ST_COUNT;
			ST_COUNT: begin
				if (hold_cnt[HOLD_BIT])	// Hold time reached
					next_state = ST_COMPLETE;
			end
			ST_COMPLETE: next_state = ST_RELEASE;
			ST_RELEASE:  next_state = ST_IDLE;
			ST_IDLE:     next_state = ST_IDLE;
			default:     next_state = ST_RESET;
		endcase
	end

	// ----------------------------------------
	// State, counter and reset output
	// ----------------------------------------
	always_ff @(posedge cpu_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_RESET;
			hold_cnt  <= '0;
			sys_rst_n <= 1'b0;
		end else begin
			case (state)
				ST_RESET: begin
					hold_cnt  <= '0;	// Clear on entry to counting
					sys_rst_n <= 1'b0;
				end
				ST_COUNT:   hold_cnt  <= hold_cnt + 1'b1;
				ST_RELEASE: sys_rst_n <= 1'b1;	// Let the system run
				default: begin
				end
			endcase

			// Manual reset wins from any state
			if (manual_reset)
				state <= ST_RESET;
			else
				state <= next_state;
		end
	end

	// Release only comes out of the release state
	a_no_release_while_counting: assert property (
		@(posedge cpu_clk) disable iff (!rst_n)
		(state == ST_COUNT) |-> !sys_rst_n
	);

endmodule

`default_nettype wire

/* hw/soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_top (
	input  logic                       cpu_clk,
	input  logic                       rst_n,
	input  logic                       manual_reset,	// Active high
	input  logic                       halt,
	input  soc_pkg::mem_req_t          mem_req,		// Processor bus
	output logic [soc_pkg::DATA_W-1:0] mem_rdata,
	output logic                       sys_ready,
	output logic [7:0]                 port_a,
	output logic                       port_lb,
	output logic                       port_lr,
	output logic                       port_lg
);
	import soc_pkg::*;

	logic              sys_rst_n;	// From the sequencer
	mem_sel_t          mem_sel;
	logic [DATA_W-1:0] ram_rdata;

	// ----------------------------------------
	// Reset
	// ----------------------------------------
	soc_reset_seq u_reset_seq (
		.cpu_clk      (cpu_clk),
		.rst_n        (rst_n),
		.manual_reset (manual_reset),
		.sys_rst_n    (sys_rst_n)
	);

	assign sys_ready = sys_rst_n;	// High once out of reset

	// ----------------------------------------
	// Bus fabric
	// ----------------------------------------
	soc_addr_decode u_addr_decode (
		.cpu_clk   (cpu_clk),
		.sys_rst_n (sys_rst_n),
		.mem_req   (mem_req),
		.ram_rdata (ram_rdata),
		.mem_sel   (mem_sel),
		.mem_rdata (mem_rdata)
	);

	soc_bram u_bram (
		.cpu_clk   (cpu_clk),
		.mem_req   (mem_req),
		.mem_sel   (mem_sel),
		.ram_rdata (ram_rdata)
	);

	soc_io_regs u_io_regs (
		.cpu_clk   (cpu_clk),
		.sys_rst_n (sys_rst_n),
		.mem_req   (mem_req),
		.mem_sel   (mem_sel),
		.halt      (halt),
		.port_a    (port_a),
		.port_lb   (port_lb),
		.port_lr   (port_lr),
		.port_lg   (port_lg)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the soc_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_soc \
	-f soc_top.f --Mdir obj_dir -o tb_soc_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi

echo "Simulation passed"
exit 0

/* soc_top.f */
hw/soc_pkg.sv
hw/soc_reset_seq.sv
hw/soc_addr_decode.sv
hw/soc_bram.sv
hw/soc_io_regs.sv
hw/soc_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_soc.sv

/* tests/tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_checker (
	input  logic                       cpu_clk,
	input  logic                       rst_n,
	input  logic                       halt,
	input  soc_pkg::mem_req_t          mem_req,
	input  logic [soc_pkg::DATA_W-1:0] mem_rdata,
	input  logic                       sys_ready,
	input  logic [7:0]                 port_a,
	input  logic                       port_lb,
	input  logic                       port_lr,
	input  logic                       port_lg
);
	import soc_pkg::*;

	string test_name = "startup";	// Set by the testbench top
	int value_errs = 0;
	int other_errs = 0;

	logic [31:0] shadow_ram [RAM_WORDS];	// Reference RAM
	logic [7:0]  shadow_pa = 8'h00;
	logic        shadow_lb = 1'b0;
	logic        rd_pend = 1'b0;	// Read strobe seen last edge
	logic [31:0] rd_exp = '0;

	task automatic value_fail(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
		value_errs++;
	endtask

	task automatic note_error(input string msg);
		$display("Error in %s: %s", test_name, msg);
		other_errs++;
	endtask

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic logic is_sdram_addr(input logic [31:0] a);
		return a[24] | a[25];
	endfunction

	function automatic logic is_io_addr(input logic [31:0] a);
		return a[22] && !is_sdram_addr(a);
	endfunction

	// Lowest set lane by priority chain
	function automatic logic [7:0] ref_lane(input logic [31:0] d, input logic [3:0] m);
		if (m[0]) return d[7:0];
		else if (m[1]) return d[15:8];
		else if (m[2]) return d[23:16];
		else if (m[3]) return d[31:24];
		else return d[7:0];
	endfunction

	// Expected read data for an address
	function automatic logic [31:0] ref_read(input logic [31:0] a);
		if (is_sdram_addr(a) || is_io_addr(a))
			return 32'h0;	// Only RAM gives data
		return shadow_ram[a[15:2]];
	endfunction

	// ----------------------------------------
	// Comparison on every rising edge
	// ----------------------------------------
	always @(posedge cpu_clk) begin
		logic [31:0] a;
		logic [7:0]  lane_byte;
		a = mem_req.addr;
		if (rst_n) begin
			if (rd_pend && mem_rdata !== rd_exp)
				value_fail("mem_rdata", rd_exp, mem_rdata);
			rd_pend = 1'b0;
			if (!sys_ready) begin	// IO held in reset
				shadow_pa = 8'h00;
				shadow_lb = 1'b0;
			end
			if (port_a !== shadow_pa)
				value_fail("port_a", {24'h0, shadow_pa}, {24'h0, port_a});
			if (port_lb !== shadow_lb)
				value_fail("port_lb", {31'h0, shadow_lb}, {31'h0, port_lb});
			if (port_lr !== halt || port_lg !== !halt)
				value_fail("status LEDs", {30'h0, halt, !halt}, {30'h0, port_lr, port_lg});
			if (sys_ready && mem_req.rstrb) begin
				rd_exp  = ref_read(a);
				rd_pend = 1'b1;
			end
			if (mem_req.wmask != 4'h0) begin
				if (!is_sdram_addr(a) && !is_io_addr(a)) begin	// RAM has no reset
					for (int i = 0; i < 4; i++)
						if (mem_req.wmask[i])
							shadow_ram[a[15:2]][i*8 +: 8] = mem_req.wdata[i*8 +: 8];
				end else if (sys_ready && is_io_addr(a) && a[15:8] == 8'h00) begin
					shadow_pa = ref_lane(mem_req.wdata, mem_req.wmask);
				end else if (sys_ready && is_io_addr(a) && a[15:8] == 8'h02) begin
					lane_byte = ref_lane(mem_req.wdata, mem_req.wmask);
					shadow_lb = lane_byte[0];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic cpu_clk
);

	// 4 ns period, 250 MHz
	initial cpu_clk = 1'b0;

	always #2 cpu_clk = ~cpu_clk;

endmodule

`default_nettype wire

/* tests/tb_soc.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_soc;
	import soc_pkg::*;

	localparam int NUM_WORDS = 16;
	localparam int PLANNED_ACCESSES = 160;	// Cycles of all tests with reset holds

	logic cpu_clk;
	logic rst_n;
	logic manual_reset;
	logic halt;
	mem_req_t mem_req;
	logic [DATA_W-1:0] mem_rdata;
	logic sys_ready;
	logic [7:0] port_a;
	logic port_lb;
	logic port_lr;
	logic port_lg;

	integer seed = 32'h633ab7b8;
	logic [13:0] words [NUM_WORDS];	// RAM indices in use

	tb_clock u_clock (.cpu_clk(cpu_clk));

	soc_top dut (.cpu_clk(cpu_clk), .rst_n(rst_n), .manual_reset(manual_reset), .halt(halt),
		.mem_req(mem_req), .mem_rdata(mem_rdata), .sys_ready(sys_ready), .port_a(port_a),
		.port_lb(port_lb), .port_lr(port_lr), .port_lg(port_lg));

	tb_checker chk (.cpu_clk(cpu_clk), .rst_n(rst_n), .halt(halt), .mem_req(mem_req),
		.mem_rdata(mem_rdata), .sys_ready(sys_ready), .port_a(port_a), .port_lb(port_lb),
		.port_lr(port_lr), .port_lg(port_lg));

	// ----------------------------------------
	// Bus driver with one access per cycle
	// ----------------------------------------
	task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] m);
		@(negedge cpu_clk);
		mem_req.addr  = a;
		mem_req.wdata = d;
		mem_req.wmask = m;
		mem_req.rstrb = 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] a);
		@(negedge cpu_clk);
		mem_req.addr  = a;
		mem_req.wmask = 4'h0;
		mem_req.rstrb = 1'b1;
	endtask

	task automatic bus_idle(input int n);
		repeat (n) begin
			@(negedge cpu_clk);
			mem_req.wmask = 4'h0;
			mem_req.rstrb = 1'b0;
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!sys_ready && n < 40) begin
			@(negedge cpu_clk);
			n++;
		end
		if (!sys_ready)
			chk.note_error("sys_ready never rose after reset");
	endtask

	function automatic logic [31:0] ram_addr(input logic [13:0] idx);
		return {16'h0, idx, 2'b00};
	endfunction

	// Watchdog
	initial begin
		#(PLANNED_ACCESSES * 4 + 1000);
		$display("Timeout, the tests did not finish in time");
		$display("Errors found");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [3:0] masks [6];
		masks = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1010, 4'b0000};
		rst_n = 1'b0;
		manual_reset = 1'b0;
		halt = 1'b0;
		mem_req = '0;
		repeat (2) @(negedge cpu_clk);
		rst_n = 1'b1;

		chk.test_name = "reset_release";
		wait_ready();
		bus_idle(2);

		chk.test_name = "ram_readback";
		for (int i = 0; i < NUM_WORDS; i++) begin
			r = $random(seed);
			words[i] = r[13:0];
			bus_write(ram_addr(words[i]), $random(seed), 4'hf);	// Defines every byte
			r = $random(seed);
			bus_write(ram_addr(words[i]), $random(seed), r[3:0]);
		end
		for (int i = 0; i < NUM_WORDS; i++)
			bus_read(ram_addr(words[i]));	// Back to back
		bus_idle(2);

		chk.test_name = "io_lanes";
		for (int i = 0; i < 6; i++) begin
			bus_write(32'h0040_0000 | {16'h0, DEV_PORT_A, 8'h0}, $random(seed), masks[i]);
			bus_write(32'h0040_0000 | {16'h0, DEV_LED, 8'h0}, $random(seed), masks[i]);
			bus_idle(1);
		end

		chk.test_name = "zero_reads";
		bus_read(32'h0040_0000);	// Port A is write only
		bus_read(32'h0040_0200);
		bus_read(32'h0040_0100);	// UART number
		bus_read(32'h0040_0300);
		bus_write(32'h0100_0000 | ram_addr(words[0]), 32'hdead_beef, 4'hf);
		bus_write(32'h0200_0000 | ram_addr(words[1]), 32'hcafe_f00d, 4'hf);
		bus_read(32'h0100_0000 | ram_addr(words[0]));
		bus_read(32'h0340_0000);
		bus_read(ram_addr(words[0]));	// Alias must be untouched
		bus_read(ram_addr(words[1]));
		bus_idle(2);

		chk.test_name = "leds_manual_reset";
		halt = 1'b1;
		bus_idle(2);
		halt = 1'b0;
		bus_write(32'h0040_0000, 32'h0000_005a, 4'h1);
		bus_idle(1);
		@(negedge cpu_clk);
		manual_reset = 1'b1;
		@(negedge cpu_clk);
		manual_reset = 1'b0;
		bus_idle(3);
		if (sys_ready)
			chk.note_error("sys_ready stayed high after a manual reset");
		wait_ready();
		bus_idle(1);
		for (int i = 0; i < NUM_WORDS; i++)
			bus_read(ram_addr(words[i]));
		bus_idle(3);

		$display("Value errors: %0d, other errors: %0d", chk.value_errs, chk.other_errs);
		if (chk.value_errs + chk.other_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
